// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// word address split as tag | index | offset
	localparam int OFFSET_W = 2;
	localparam int INDEX_W = 3;
	localparam int TAG_W = 11;

	localparam int LINE_WORDS = 4;
	localparam int NUM_LINES = 8;
	localparam int MEM_WORDS = 256;
	localparam int MEM_LINE_BITS = $clog2(MEM_WORDS / LINE_WORDS);
	// cycles from bus start to read data
	localparam int MEM_LATENCY = 4;
	// credits per port
	localparam int REQ_DEPTH = 2;

	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;
	// word 0 sits in the low bits
	typedef word_t [LINE_WORDS-1:0] line_t;

	function automatic tag_t addr_tag(addr_t a);
		return a[OFFSET_W+INDEX_W +: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(addr_t a);
		return a[OFFSET_W-1:0];
	endfunction

	function automatic line_addr_t addr_line(addr_t a);
		return a[OFFSET_W +: TAG_W+INDEX_W];
	endfunction

endpackage

`default_nettype wire

// File: rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// request as seen on a processor port
	typedef struct packed {
		logic is_write;
		mem_pkg::addr_t addr;
		mem_pkg::word_t wdata;
	} port_req_t;

	// one valid cycle per request, in order
	typedef struct packed {
		logic valid;
		mem_pkg::word_t rdata;
	} port_rsp_t;

	// line transfer between a cache and the shared memory
	typedef struct packed {
		logic valid;
		logic is_write;
		mem_pkg::line_addr_t line_addr;
		mem_pkg::line_t wline;
	} mem_req_t;

	typedef struct packed {
		logic done;
		mem_pkg::line_t rline;
	} mem_rsp_t;

	typedef enum logic {
		CLIENT_I,
		CLIENT_D
	} client_e;

endpackage

`default_nettype wire

// File: rtl/req_queue.sv
`timescale 1ns/100ps
`default_nettype none

module req_queue (
	input wire clk,
	input wire reset_n,
	input wire i_push,
	input wire bus_pkg::port_req_t i_req,
	input wire i_pop,
	output bus_pkg::port_req_t o_head,
	output logic o_head_valid,
	output logic o_credit
);
	import mem_pkg::*;
	import bus_pkg::*;

	port_req_t entries [REQ_DEPTH];
	logic [$clog2(REQ_DEPTH)-1:0] rd_ptr;
	logic [$clog2(REQ_DEPTH)-1:0] wr_ptr;
	logic [$clog2(REQ_DEPTH+1)-1:0] count;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			o_credit <= 1'b0;
		end else begin
			if (i_push) wr_ptr <= wr_ptr + 1'b1;
			if (i_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// sender gets its credit back one cycle after the entry leaves
			o_credit <= i_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (i_push) entries[wr_ptr] <= i_req;
	end

	assign o_head = entries[rd_ptr];
	assign o_head_valid = (count != '0);

endmodule

`default_nettype wire

// File: rtl/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache (
	input wire clk,
	input wire reset_n,
	input wire bus_pkg::port_req_t i_req,
	input wire i_req_valid,
	output logic o_pop,
	output bus_pkg::port_rsp_t o_rsp,
	output bus_pkg::mem_req_t o_mem_req,
	input wire bus_pkg::mem_rsp_t i_mem_rsp
);
	import mem_pkg::*;

	typedef enum logic {
		IDLE,
		FILL
	} state_t;

	state_t state;
	tag_t tags [NUM_LINES];
	line_t lines [NUM_LINES];
	logic [NUM_LINES-1:0] line_valid;

	tag_t req_tag;
	index_t req_index;
	offset_t req_offset;
	logic hit;
	logic rsp_valid;
	word_t rsp_data;

	assign req_tag = addr_tag(i_req.addr);
	assign req_index = addr_index(i_req.addr);
	assign req_offset = addr_offset(i_req.addr);
	assign hit = line_valid[req_index] && (tags[req_index] == req_tag);

	// writes are not served here, they leave at once with a zero answer
	assign o_pop = (state == IDLE) && i_req_valid && (hit || i_req.is_write);

	// head entry stays put during the fill, so its address drives the bus
	assign o_mem_req.valid = (state == FILL);
	assign o_mem_req.is_write = 1'b0;
	assign o_mem_req.line_addr = addr_line(i_req.addr);
	assign o_mem_req.wline = '0;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			line_valid <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= o_pop;
			case (state)
				IDLE: begin
					if (i_req_valid && !i_req.is_write && !hit) state <= FILL;
				end
				FILL: begin
					if (i_mem_rsp.done) begin
						line_valid[req_index] <= 1'b1;
						state <= IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (o_pop) rsp_data <= i_req.is_write ? '0 : lines[req_index][req_offset];
		if ((state == FILL) && i_mem_rsp.done) begin
			lines[req_index] <= i_mem_rsp.rline;
			tags[req_index] <= req_tag;
		end
	end

	assign o_rsp.valid = rsp_valid;
	assign o_rsp.rdata = rsp_data;

endmodule

`default_nettype wire

// File: rtl/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache (
	input wire clk,
	input wire reset_n,
	input wire bus_pkg::port_req_t i_req,
	input wire i_req_valid,
	output logic o_pop,
	output bus_pkg::port_rsp_t o_rsp,
	output bus_pkg::mem_req_t o_mem_req,
	input wire bus_pkg::mem_rsp_t i_mem_rsp
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WRITEBACK,
		FILL
	} state_t;

	state_t state;
	tag_t tags [NUM_LINES];
	line_t lines [NUM_LINES];
	logic [NUM_LINES-1:0] line_valid;
	logic [NUM_LINES-1:0] line_dirty;

	tag_t req_tag;
	index_t req_index;
	offset_t req_offset;
	logic hit;
	logic victim_dirty;
	logic rsp_valid;
	word_t rsp_data;

	assign req_tag = addr_tag(i_req.addr);
	assign req_index = addr_index(i_req.addr);
	assign req_offset = addr_offset(i_req.addr);
	assign hit = line_valid[req_index] && (tags[req_index] == req_tag);
	assign victim_dirty = line_valid[req_index] && line_dirty[req_index];

	// a miss leaves the entry at the head and retries as a hit after the fill
	assign o_pop = (state == IDLE) && i_req_valid && hit;

	// request stays up across writeback and fill so the arbiter keeps the grant
	assign o_mem_req.valid = (state != IDLE);
	assign o_mem_req.is_write = (state == WRITEBACK);
	// victim goes back to the line it came from
	assign o_mem_req.line_addr = (state == WRITEBACK) ? {tags[req_index], req_index}
		: addr_line(i_req.addr);
	assign o_mem_req.wline = lines[req_index];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			line_valid <= '0;
			line_dirty <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= o_pop;
			case (state)
				IDLE: begin
					if (o_pop && i_req.is_write) line_dirty[req_index] <= 1'b1;
					if (i_req_valid && !hit) begin
						state <= victim_dirty ? WRITEBACK : FILL;
					end
				end
				WRITEBACK: begin
					if (i_mem_rsp.done) state <= FILL;
				end
				FILL: begin
					if (i_mem_rsp.done) begin
						line_valid[req_index] <= 1'b1;
						line_dirty[req_index] <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (o_pop) begin
			if (i_req.is_write) begin
				lines[req_index][req_offset] <= i_req.wdata;
				// writes echo the stored word
				rsp_data <= i_req.wdata;
			end else begin
				rsp_data <= lines[req_index][req_offset];
			end
		end
		if ((state == FILL) && i_mem_rsp.done) begin
			lines[req_index] <= i_mem_rsp.rline;
			tags[req_index] <= req_tag;
		end
	end

	assign o_rsp.valid = rsp_valid;
	assign o_rsp.rdata = rsp_data;

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
	input wire clk,
	input wire reset_n,
	input wire bus_pkg::mem_req_t i_ireq,
	input wire bus_pkg::mem_req_t i_dreq,
	output bus_pkg::mem_rsp_t o_irsp,
	output bus_pkg::mem_rsp_t o_drsp,
	output bus_pkg::mem_req_t o_mem_req,
	input wire bus_pkg::mem_rsp_t i_mem_rsp
);
	import bus_pkg::*;

	client_e owner;
	logic owner_req;
	logic other_req;

	assign owner_req = (owner == CLIENT_I) ? i_ireq.valid : i_dreq.valid;
	assign other_req = (owner == CLIENT_I) ? i_dreq.valid : i_ireq.valid;

	// a client holds its request from start to its final done, so the turn
	// ends only once the owner drops it
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			owner <= CLIENT_I;
		end else if (!owner_req && other_req) begin
			owner <= (owner == CLIENT_I) ? CLIENT_D : CLIENT_I;
		end
	end

	assign o_mem_req = (owner == CLIENT_I) ? i_ireq : i_dreq;

	// line data fans out, done only reaches the owner
	assign o_irsp.done = i_mem_rsp.done && (owner == CLIENT_I);
	assign o_irsp.rline = i_mem_rsp.rline;
	assign o_drsp.done = i_mem_rsp.done && (owner == CLIENT_D);
	assign o_drsp.rline = i_mem_rsp.rline;

endmodule

`default_nettype wire

// File: rtl/main_memory.sv
`timescale 1ns/100ps
`default_nettype none

module main_memory (
	input wire clk,
	input wire reset_n,
	input wire bus_pkg::mem_req_t i_req,
	output bus_pkg::mem_rsp_t o_rsp
);
	import mem_pkg::*;

	word_t mem [MEM_WORDS];
	logic busy;
	logic done_q;
	logic read_ready;
	logic [$clog2(MEM_LATENCY+1)-1:0] cycle_cnt;
	logic [MEM_LINE_BITS-1:0] line_idx;
	line_t rline_q;

	// lines wrap onto the small array
	assign line_idx = i_req.line_addr[MEM_LINE_BITS-1:0];
	assign read_ready = busy && !done_q
		&& (cycle_cnt == $bits(cycle_cnt)'(MEM_LATENCY - 1));

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			done_q <= 1'b0;
			cycle_cnt <= '0;
		end else if (!busy) begin
			if (i_req.valid) begin
				busy <= 1'b1;
				// write finishes in the next cycle
				done_q <= i_req.is_write;
				cycle_cnt <= 1'b1;
			end
		end else if (done_q) begin
			busy <= 1'b0;
			done_q <= 1'b0;
		end else begin
			if (read_ready) done_q <= 1'b1;
			cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && i_req.valid && i_req.is_write) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				mem[{line_idx, offset_t'(w)}] <= i_req.wline[w];
			end
		end
		if (read_ready) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				rline_q[w] <= mem[{line_idx, offset_t'(w)}];
			end
		end
	end

	assign o_rsp.done = done_q;
	assign o_rsp.rline = rline_q;

endmodule

`default_nettype wire

// File: rtl/split_cache_mem.sv
`timescale 1ns/100ps
`default_nettype none

module split_cache_mem (
	input wire clk,
	input wire reset_n,
	input wire bus_pkg::port_req_t i_ireq,
	input wire i_ireq_push,
	output logic o_icredit,
	output bus_pkg::port_rsp_t o_irsp,
	input wire bus_pkg::port_req_t i_dreq,
	input wire i_dreq_push,
	output logic o_dcredit,
	output bus_pkg::port_rsp_t o_drsp
);
	import bus_pkg::*;

	port_req_t ihead;
	port_req_t dhead;
	logic ihead_valid;
	logic dhead_valid;
	logic ipop;
	logic dpop;
	mem_req_t imem_req;
	mem_req_t dmem_req;
	mem_req_t mem_req;
	mem_rsp_t imem_rsp;
	mem_rsp_t dmem_rsp;
	mem_rsp_t mem_rsp;

	req_queue ireq_queue_i (
		.clk(clk),
		.reset_n(reset_n),
		.i_push(i_ireq_push),
		.i_req(i_ireq),
		.i_pop(ipop),
		.o_head(ihead),
		.o_head_valid(ihead_valid),
		.o_credit(o_icredit)
	);

	req_queue dreq_queue_i (
		.clk(clk),
		.reset_n(reset_n),
		.i_push(i_dreq_push),
		.i_req(i_dreq),
		.i_pop(dpop),
		.o_head(dhead),
		.o_head_valid(dhead_valid),
		.o_credit(o_dcredit)
	);

	icache icache_i (
		.clk(clk),
		.reset_n(reset_n),
		.i_req(ihead),
		.i_req_valid(ihead_valid),
		.o_pop(ipop),
		.o_rsp(o_irsp),
		.o_mem_req(imem_req),
		.i_mem_rsp(imem_rsp)
	);

	dcache dcache_i (
		.clk(clk),
		.reset_n(reset_n),
		.i_req(dhead),
		.i_req_valid(dhead_valid),
		.o_pop(dpop),
		.o_rsp(o_drsp),
		.o_mem_req(dmem_req),
		.i_mem_rsp(dmem_rsp)
	);

	mem_arbiter mem_arbiter_i (
		.clk(clk),
		.reset_n(reset_n),
		.i_ireq(imem_req),
		.i_dreq(dmem_req),
		.o_irsp(imem_rsp),
		.o_drsp(dmem_rsp),
		.o_mem_req(mem_req),
		.i_mem_rsp(mem_rsp)
	);

	main_memory main_memory_i (
		.clk(clk),
		.reset_n(reset_n),
		.i_req(mem_req),
		.o_rsp(mem_rsp)
	);

endmodule

`default_nettype wire

// File: test/tb_split_cache_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_split_cache_mem;
	import mem_pkg::*;
	import bus_pkg::*;

	localparam logic PORT_I = 1'b0;
	localparam logic PORT_D = 1'b1;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES = 16;

	typedef struct packed {
		logic [2:0] test_id;
		logic port;
		logic is_write;
		addr_t addr;
		word_t data;
	} stim_t;

	logic clk;
	logic reset_n;
	port_req_t ireq;
	logic ireq_push;
	logic icredit;
	port_rsp_t irsp;
	port_req_t dreq;
	logic dreq_push;
	logic dcredit;
	port_rsp_t drsp;

	stim_t stim [$];
	word_t model [MEM_WORDS];
	word_t exp_i [$];
	word_t exp_d [$];
	logic [31:0] lfsr;
	int credits [2];
	int pushed [2];
	int returned [2];
	int answered [2];
	int errors;
	int checks;
	int cycle_limit;
	int watchdog;

	split_cache_mem split_cache_mem_i (
		.clk(clk),
		.reset_n(reset_n),
		.i_ireq(ireq),
		.i_ireq_push(ireq_push),
		.o_icredit(icredit),
		.o_irsp(irsp),
		.i_dreq(dreq),
		.i_dreq_push(dreq_push),
		.o_dcredit(dcredit),
		.o_drsp(drsp)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'hD000_0001 : 32'h0);
	endfunction

	// one step per bit, low bit first
	task automatic next_word(output word_t w);
		for (int b = 0; b < 16; b++) begin
			lfsr = lfsr_step(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic add_entry(input int test_id, input logic port, input logic is_write,
		input addr_t addr);
		stim_t e;
		word_t w;
		w = '0;
		if (is_write) next_word(w);
		e.test_id = 3'(test_id);
		e.port = port;
		e.is_write = is_write;
		e.addr = addr;
		e.data = w;
		stim.push_back(e);
	endtask

	// A and A + 32 share an index, so those pairs evict each other
	task automatic build_table();
		add_entry(2, PORT_D, 1'b1, 16'h0010);
		add_entry(2, PORT_D, 1'b0, 16'h0010);
		add_entry(2, PORT_D, 1'b1, 16'h0011);
		add_entry(2, PORT_D, 1'b0, 16'h0011);
		add_entry(3, PORT_D, 1'b1, 16'h0024);
		add_entry(3, PORT_D, 1'b1, 16'h0044);
		add_entry(3, PORT_D, 1'b0, 16'h0024);
		// pushes the 0x10 line out to memory
		add_entry(3, PORT_D, 1'b1, 16'h0030);
		add_entry(4, PORT_I, 1'b0, 16'h0010);
		add_entry(4, PORT_I, 1'b0, 16'h0011);
		add_entry(4, PORT_I, 1'b0, 16'h0024);
		add_entry(4, PORT_I, 1'b0, 16'h0044);
		add_entry(5, PORT_I, 1'b0, 16'h0024);
		add_entry(5, PORT_D, 1'b1, 16'h0090);
		add_entry(5, PORT_I, 1'b0, 16'h0044);
		add_entry(5, PORT_D, 1'b0, 16'h0030);
		add_entry(5, PORT_I, 1'b0, 16'h0010);
		add_entry(5, PORT_D, 1'b0, 16'h0090);
		add_entry(5, PORT_I, 1'b0, 16'h0011);
	endtask

	task automatic take_response(input int p, input port_rsp_t rsp);
		word_t want;
		logic found;
		want = '0;
		found = 1'b0;
		if (p == 0 && exp_i.size() > 0) begin
			want = exp_i.pop_front();
			found = 1'b1;
		end else if (p == 1 && exp_d.size() > 0) begin
			want = exp_d.pop_front();
			found = 1'b1;
		end
		answered[p]++;
		if (!found) begin
			errors++;
			$display("port %0d gave a response with no request outstanding", p);
		end else begin
			check_value(p == 0 ? "o_irsp.rdata" : "o_drsp.rdata", 32'(rsp.rdata), 32'(want));
		end
	endtask

	task automatic sample_outputs();
		if (icredit) begin
			credits[0]++;
			returned[0]++;
		end
		if (dcredit) begin
			credits[1]++;
			returned[1]++;
		end
		if (irsp.valid) take_response(0, irsp);
		if (drsp.valid) take_response(1, drsp);
		for (int p = 0; p < 2; p++) begin
			if (pushed[p] - answered[p] > REQ_DEPTH || credits[p] > REQ_DEPTH) begin
				errors++;
				$display("port %0d went past its %0d credits", p, REQ_DEPTH);
			end
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	task automatic tick();
		@(negedge clk);
		ireq_push = 1'b0;
		dreq_push = 1'b0;
		sample_outputs();
	endtask

	task automatic push_entry(input stim_t e);
		port_req_t r;
		word_t want;
		while (credits[e.port] == 0) tick();
		r.is_write = e.is_write;
		r.addr = e.addr;
		r.wdata = e.data;
		if (!e.is_write) begin
			want = model[e.addr[7:0]];
		end else if (e.port == PORT_D) begin
			model[e.addr[7:0]] = e.data;
			want = e.data;
		end else begin
			// instruction port drops writes and answers zero
			want = '0;
		end
		credits[e.port]--;
		pushed[e.port]++;
		if (e.port == PORT_I) begin
			ireq = r;
			ireq_push = 1'b1;
			exp_i.push_back(want);
		end else begin
			dreq = r;
			dreq_push = 1'b1;
			exp_d.push_back(want);
		end
		tick();
	endtask

	task automatic drain();
		while (exp_i.size() != 0 || exp_d.size() != 0) begin
			tick();
		end
	endtask

	function automatic string test_name(int id);
		case (id)
			1: return "idle after reset";
			2: return "write then read";
			3: return "dirty eviction and refill";
			4: return "fetch after write-back";
			5: return "interleaved misses";
			6: return "credit accounting";
			default: return "unknown";
		endcase
	endfunction

	task automatic report_test(input int id, input int errors_before);
		$display("test %0d %s: %s", id, test_name(id),
			(errors == errors_before) ? "ok" : "failed");
	endtask

	initial begin
		int errors_before;
		int current;
		clk = 1'b0;
		reset_n = 1'b0;
		ireq = '0;
		ireq_push = 1'b0;
		dreq = '0;
		dreq_push = 1'b0;
		lfsr = 32'h146c_7548;
		errors = 0;
		checks = 0;
		for (int p = 0; p < 2; p++) begin
			credits[p] = REQ_DEPTH;
			pushed[p] = 0;
			returned[p] = 0;
			answered[p] = 0;
		end
		foreach (model[a]) model[a] = '0;
		build_table();
		cycle_limit = stim.size() * (2 * MEM_LATENCY + 20) + 200;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		errors_before = errors;
		repeat (IDLE_CYCLES) tick();
		check_value("credit and response events", returned[0] + returned[1]
			+ answered[0] + answered[1], 0);
		report_test(1, errors_before);

		current = stim[0].test_id;
		errors_before = errors;
		foreach (stim[n]) begin
			if (stim[n].test_id != current) begin
				drain();
				report_test(current, errors_before);
				current = stim[n].test_id;
				errors_before = errors;
			end
			push_entry(stim[n]);
		end
		drain();
		report_test(current, errors_before);

		errors_before = errors;
		check_value("o_icredit count", returned[0], pushed[0]);
		check_value("o_irsp count", answered[0], pushed[0]);
		check_value("o_dcredit count", returned[1], pushed[1]);
		check_value("o_drsp count", answered[1], pushed[1]);
		report_test(6, errors_before);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		watchdog = 0;
		@(posedge reset_n);
		while (watchdog < cycle_limit) begin
			@(posedge clk);
			watchdog++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
rtl/mem_pkg.sv
rtl/bus_pkg.sv
rtl/req_queue.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/main_memory.sv
rtl/split_cache_mem.sv
test/tb_split_cache_mem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_split_cache_mem -f flist.f -o tb_split_cache_mem \
	&& ./obj_dir/tb_split_cache_mem > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "^TEST PASS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
